//--- hw/lcCtrl_params.svh
// Widths and counts of the life cycle state vector
// Sparse OTP word widths, decoded widths and error flag count
`ifndef LC_CTRL_PARAMS_SVH
`define LC_CTRL_PARAMS_SVH

// Redundant copies of the decoded state
`define LC_DEC_NUM_REP 3
// Width of a single decoded state copy
`define LC_DEC_ST_WIDTH 5
// Width of the plain decoded transition count
`define LC_CNT_WIDTH 5

// Sparse OTP words
`define LC_STATE_WIDTH 32
`define LC_CNT_WORD_WIDTH 16

// Counter saturation point, no transition allowed beyond it
`define LC_MAX_CNT 24
// Number of decoder error flags
`define LC_NUM_ERR 6

`endif

//--- hw/lcCtrlStatePkg.sv
// Life cycle state types
// Sparse OTP state and counter encodings, decoded state,
// identity and count types, sparse to decoded state mapping
`include "lcCtrl_params.svh"

package lcCtrlStatePkg;

  //////////////////////////////
  // Sparse OTP encodings
  //////////////////////////////

  // Persistent state word, listed in rank order
  typedef enum logic [`LC_STATE_WIDTH-1:0] {
    LcStRaw           = 32'h0000_0000, LcStTestUnlocked0 = 32'h1c3a_5e21,
    LcStTestLocked0   = 32'h2b47_90d6, LcStTestUnlocked1 = 32'h3e95_c4a8,
    LcStTestLocked1   = 32'h4d1b_7f03, LcStTestUnlocked2 = 32'h56e2_083c,
    LcStTestLocked2   = 32'h6a7d_b15e, LcStTestUnlocked3 = 32'h71c4_6e97,
    LcStTestLocked3   = 32'h8f38_2ac1, LcStTestUnlocked4 = 32'h9306_d57b,
    LcStTestLocked4   = 32'ha5ed_4312, LcStTestUnlocked5 = 32'hb28c_f964,
    LcStTestLocked5   = 32'hc649_1eab, LcStTestUnlocked6 = 32'hd9f7_6235,
    LcStTestLocked6   = 32'he1a3_bc48, LcStTestUnlocked7 = 32'hf45e_07d9,
    LcStDev           = 32'h0b6c_e38f, LcStProd          = 32'h17d1_2c56,
    LcStProdEnd       = 32'h28ab_f61d, LcStRma           = 32'h3a59_8dc2,
    LcStScrap         = 32'h4ce6_5a7b
  } lcStateE;

  // Transition counter word
  typedef enum logic [`LC_CNT_WORD_WIDTH-1:0] {
    LcCnt0  = 16'h0000, LcCnt1  = 16'h1a5c, LcCnt2  = 16'h2b93, LcCnt3  = 16'h3c46,
    LcCnt4  = 16'h4d2e, LcCnt5  = 16'h5eb1, LcCnt6  = 16'h6f78, LcCnt7  = 16'h70c5,
    LcCnt8  = 16'h819a, LcCnt9  = 16'h92e7, LcCnt10 = 16'ha35d, LcCnt11 = 16'hb4a2,
    LcCnt12 = 16'hc51f, LcCnt13 = 16'hd6e8, LcCnt14 = 16'he734, LcCnt15 = 16'hf86b,
    LcCnt16 = 16'h09d7, LcCnt17 = 16'h1be4, LcCnt18 = 16'h2c1a, LcCnt19 = 16'h3d79,
    LcCnt20 = 16'h4e86, LcCnt21 = 16'h5f2d, LcCnt22 = 16'h60b3, LcCnt23 = 16'h71ce,
    LcCnt24 = 16'h825f
  } lcCntE;

  //////////////////////////////
  // Decoded representation
  //////////////////////////////

  // Values 0 to 20 equal the rank of the OTP state
  // Escalate, PostTrans and Invalid exist only in the decoded form
  typedef enum logic [`LC_DEC_ST_WIDTH-1:0] {
    DecLcStRaw, DecLcStTestUnlocked0, DecLcStTestLocked0, DecLcStTestUnlocked1,
    DecLcStTestLocked1, DecLcStTestUnlocked2, DecLcStTestLocked2, DecLcStTestUnlocked3,
    DecLcStTestLocked3, DecLcStTestUnlocked4, DecLcStTestLocked4, DecLcStTestUnlocked5,
    DecLcStTestLocked5, DecLcStTestUnlocked6, DecLcStTestLocked6, DecLcStTestUnlocked7,
    DecLcStDev, DecLcStProd, DecLcStProdEnd, DecLcStRma, DecLcStScrap,
    DecLcStEscalate, DecLcStPostTrans, DecLcStInvalid
  } decLcStateE;

  typedef decLcStateE [`LC_DEC_NUM_REP-1:0] extDecLcStateT;

  typedef enum logic [1:0] {
    DecLcIdBlank, DecLcIdPersonalized, DecLcIdInvalid
  } decLcIdStateE;

  typedef logic [`LC_CNT_WIDTH-1:0] decLcCntT;

  // Sparse code to decoded state, Invalid for any unknown code
  function automatic decLcStateE lcStateToDec(lcStateE st);
    unique case (st)
      LcStRaw:           return DecLcStRaw;
      LcStTestUnlocked0: return DecLcStTestUnlocked0;
      LcStTestLocked0:   return DecLcStTestLocked0;
      LcStTestUnlocked1: return DecLcStTestUnlocked1;
      LcStTestLocked1:   return DecLcStTestLocked1;
      LcStTestUnlocked2: return DecLcStTestUnlocked2;
      LcStTestLocked2:   return DecLcStTestLocked2;
      LcStTestUnlocked3: return DecLcStTestUnlocked3;
      LcStTestLocked3:   return DecLcStTestLocked3;
      LcStTestUnlocked4: return DecLcStTestUnlocked4;
      LcStTestLocked4:   return DecLcStTestLocked4;
      LcStTestUnlocked5: return DecLcStTestUnlocked5;
      LcStTestLocked5:   return DecLcStTestLocked5;
      LcStTestUnlocked6: return DecLcStTestUnlocked6;
      LcStTestLocked6:   return DecLcStTestLocked6;
      LcStTestUnlocked7: return DecLcStTestUnlocked7;
      LcStDev:           return DecLcStDev;
      LcStProd:          return DecLcStProd;
      LcStProdEnd:       return DecLcStProdEnd;
      LcStRma:           return DecLcStRma;
      LcStScrap:         return DecLcStScrap;
      default:           return DecLcStInvalid;
    endcase
  endfunction

endpackage

//--- hw/lcCtrlPkg.sv
// Life cycle controller types
// Multibit true/false flag, main FSM states, error flag positions

package lcCtrlPkg;

  // Multibit flag, every value other than On and Off is invalid
  typedef enum logic [3:0] {
    On  = 4'b0101,
    Off = 4'b1010
  } lcTxT;

  //////////////////////////////
  // Main FSM
  //////////////////////////////

  // The last four states are terminal and hold until reset
  typedef enum logic [2:0] {
    ResetSt,
    IdleSt,
    TransCheckSt,
    PostTransSt,
    EscalateSt,
    InvalidSt,
    ScrapSt
  } fsmStateE;

  // Position of each decoder error flag
  typedef enum int unsigned {
    ErrValid     = 0,
    ErrState     = 1,
    ErrCnt       = 2,
    ErrSecrets   = 3,
    ErrZeroCnt   = 4,
    ErrPersoTest = 5
  } errBitE;

endpackage

//--- hw/lcDecIf.sv
// Decoded life cycle vector bundle
// Decoder side drives, FSM side reads
`timescale 1ns/1ps
`include "lcCtrl_params.svh"

interface lcDecIf;

  // Redundant decoded state, all copies equal
  lcCtrlStatePkg::extDecLcStateT decState;
  // Plain transition count, all ones when not decoded
  lcCtrlStatePkg::decLcCntT      decCnt;
  lcCtrlStatePkg::decLcIdStateE  decIdState;
  // One flag per error source, see errBitE
  logic [`LC_NUM_ERR-1:0]        stateErr;

  modport decoder (
    output decState, decCnt, decIdState, stateErr
  );

  modport fsm (
    input decState, decCnt, decIdState, stateErr
  );

endinterface

//--- hw/lcCtrlStateDecode.sv
// Life cycle state decoder
// Combinational decode of the OTP vector into the redundant form,
// error flags and decode checks
`timescale 1ns/1ps
`include "lcCtrl_params.svh"

module lcCtrlStateDecode (
  // Sampling clock for the checks only
  input  logic                    clk_i,
  // OTP life cycle vector
  input  logic                    lcStateValid_i,
  input  lcCtrlStatePkg::lcStateE lcState_i,
  input  lcCtrlStatePkg::lcCntE   lcCnt_i,
  input  lcCtrlPkg::lcTxT         secretsValid_i,
  // Main FSM state
  input  lcCtrlPkg::fsmStateE     fsmState_i,
  // Decoded vector
  lcDecIf.decoder                 dec_o
);

  // Single decoded copy, replicated at the end
  lcCtrlStatePkg::decLcStateE decSt;

  //////////////////////////////
  // Decode
  //////////////////////////////

  always_comb begin : decodeComb
    // Defaults are the ResetSt output
    decSt            = lcCtrlStatePkg::DecLcStInvalid;
    dec_o.decCnt     = {`LC_CNT_WIDTH{1'b1}};
    dec_o.decIdState = lcCtrlStatePkg::DecLcIdInvalid;
    dec_o.stateErr   = '0;

    unique case (fsmState_i)
      // Nothing decoded before OTP is read
      lcCtrlPkg::ResetSt: begin
      end
      // Terminal states are not in OTP, fixed decode
      lcCtrlPkg::EscalateSt:  decSt = lcCtrlStatePkg::DecLcStEscalate;
      lcCtrlPkg::PostTransSt: decSt = lcCtrlStatePkg::DecLcStPostTrans;
      lcCtrlPkg::InvalidSt:   decSt = lcCtrlStatePkg::DecLcStInvalid;
      lcCtrlPkg::ScrapSt:     decSt = lcCtrlStatePkg::DecLcStScrap;
      // Idle and transition check decode continuously
      default: begin
        // OTP must stay valid outside ResetSt
        dec_o.stateErr[lcCtrlPkg::ErrValid] = ~lcStateValid_i;

        // Unknown sparse state code
        decSt = lcCtrlStatePkg::lcStateToDec(lcState_i);
        dec_o.stateErr[lcCtrlPkg::ErrState] = (decSt == lcCtrlStatePkg::DecLcStInvalid);

        unique case (lcCnt_i)
          lcCtrlStatePkg::LcCnt0:  dec_o.decCnt = 5'd0;
          lcCtrlStatePkg::LcCnt1:  dec_o.decCnt = 5'd1;
          lcCtrlStatePkg::LcCnt2:  dec_o.decCnt = 5'd2;
          lcCtrlStatePkg::LcCnt3:  dec_o.decCnt = 5'd3;
          lcCtrlStatePkg::LcCnt4:  dec_o.decCnt = 5'd4;
          lcCtrlStatePkg::LcCnt5:  dec_o.decCnt = 5'd5;
          lcCtrlStatePkg::LcCnt6:  dec_o.decCnt = 5'd6;
          lcCtrlStatePkg::LcCnt7:  dec_o.decCnt = 5'd7;
          lcCtrlStatePkg::LcCnt8:  dec_o.decCnt = 5'd8;
          lcCtrlStatePkg::LcCnt9:  dec_o.decCnt = 5'd9;
          lcCtrlStatePkg::LcCnt10: dec_o.decCnt = 5'd10;
          lcCtrlStatePkg::LcCnt11: dec_o.decCnt = 5'd11;
          lcCtrlStatePkg::LcCnt12: dec_o.decCnt = 5'd12;
          lcCtrlStatePkg::LcCnt13: dec_o.decCnt = 5'd13;
          lcCtrlStatePkg::LcCnt14: dec_o.decCnt = 5'd14;
          lcCtrlStatePkg::LcCnt15: dec_o.decCnt = 5'd15;
          lcCtrlStatePkg::LcCnt16: dec_o.decCnt = 5'd16;
          lcCtrlStatePkg::LcCnt17: dec_o.decCnt = 5'd17;
          lcCtrlStatePkg::LcCnt18: dec_o.decCnt = 5'd18;
          lcCtrlStatePkg::LcCnt19: dec_o.decCnt = 5'd19;
          lcCtrlStatePkg::LcCnt20: dec_o.decCnt = 5'd20;
          lcCtrlStatePkg::LcCnt21: dec_o.decCnt = 5'd21;
          lcCtrlStatePkg::LcCnt22: dec_o.decCnt = 5'd22;
          lcCtrlStatePkg::LcCnt23: dec_o.decCnt = 5'd23;
          lcCtrlStatePkg::LcCnt24: dec_o.decCnt = 5'd24;
          // Unknown counter code, count stays all ones
          default: dec_o.stateErr[lcCtrlPkg::ErrCnt] = 1'b1;
        endcase

        // Identity follows the secrets flag
        unique case (secretsValid_i)
          lcCtrlPkg::Off: dec_o.decIdState = lcCtrlStatePkg::DecLcIdBlank;
          lcCtrlPkg::On:  dec_o.decIdState = lcCtrlStatePkg::DecLcIdPersonalized;
          default:        dec_o.stateErr[lcCtrlPkg::ErrSecrets] = 1'b1;
        endcase

        // Any state past Raw needs a nonzero count
        if (lcState_i != lcCtrlStatePkg::LcStRaw && lcCnt_i == lcCtrlStatePkg::LcCnt0) begin
          dec_o.stateErr[lcCtrlPkg::ErrZeroCnt] = 1'b1;
        end

        // No provisioned secrets in Raw or test states
        if (secretsValid_i == lcCtrlPkg::On &&
            !(lcState_i inside {lcCtrlStatePkg::LcStDev,
                                lcCtrlStatePkg::LcStProd,
                                lcCtrlStatePkg::LcStProdEnd,
                                lcCtrlStatePkg::LcStRma,
                                lcCtrlStatePkg::LcStScrap})) begin
          dec_o.stateErr[lcCtrlPkg::ErrPersoTest] = 1'b1;
        end
      end
    endcase

    // Same value in every copy
    dec_o.decState = lcCtrlStatePkg::extDecLcStateT'({`LC_DEC_NUM_REP{decSt}});
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Redundant copies never diverge, whatever the FSM presents
  copiesAgreeA: assert property (@(posedge clk_i)
    dec_o.decState == {`LC_DEC_NUM_REP{dec_o.decState[0]}});

  // While the FSM sits in ResetSt no error reaches it
  resetNoErrA: assert property (@(posedge clk_i)
    (fsmState_i == lcCtrlPkg::ResetSt) |-> (dec_o.stateErr == '0));

endmodule

//--- hw/lcCtrlFsm.sv
// Life cycle main FSM
// State register, monitoring of the decoded vector,
// transition legality check and result strobes
`timescale 1ns/1ps
`include "lcCtrl_params.svh"

module lcCtrlFsm (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    escalate_i,
  // Transition request strobe and its target
  input  logic                    transReq_i,
  input  lcCtrlStatePkg::lcStateE transTarget_i,
  // Decoded vector
  lcDecIf.fsm                     dec_i,
  output lcCtrlPkg::fsmStateE     fsmState_o,
  // One-cycle result strobes
  output logic                    transOk_o,
  output logic                    transErr_o
);

  lcCtrlPkg::fsmStateE        stateD;
  lcCtrlPkg::fsmStateE        stateQ;
  // Target held from the request to the check
  lcCtrlStatePkg::lcStateE    targetQ;
  lcCtrlStatePkg::decLcStateE targetDec;
  logic                       transLegal;
  logic                       transOkD;
  logic                       transErrD;

  //////////////////////////////
  // Legality check
  //////////////////////////////

  // Rank of the target equals its decoded value
  assign targetDec = lcCtrlStatePkg::lcStateToDec(targetQ);

  // Strictly forward moves only, and the counter must have room left
  assign transLegal = (targetDec != lcCtrlStatePkg::DecLcStInvalid) &&
                      (targetDec > dec_i.decState[0]) &&
                      (dec_i.decCnt < `LC_MAX_CNT);

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin : nextStateComb
    stateD    = stateQ;
    transOkD  = 1'b0;
    transErrD = 1'b0;

    unique case (stateQ)
      // OTP vector is read after one cycle
      lcCtrlPkg::ResetSt: stateD = lcCtrlPkg::IdleSt;
      lcCtrlPkg::IdleSt: begin
        // Escalation first, then decode errors, then scrap
        if (escalate_i) begin
          stateD = lcCtrlPkg::EscalateSt;
        end else if (|dec_i.stateErr) begin
          stateD = lcCtrlPkg::InvalidSt;
        end else if (dec_i.decState[0] == lcCtrlStatePkg::DecLcStScrap) begin
          stateD = lcCtrlPkg::ScrapSt;
        end else if (transReq_i) begin
          stateD = lcCtrlPkg::TransCheckSt;
        end
      end
      // Judge the request, exactly one strobe fires
      lcCtrlPkg::TransCheckSt: begin
        transOkD  = transLegal;
        transErrD = ~transLegal;
        stateD    = transLegal ? lcCtrlPkg::PostTransSt : lcCtrlPkg::IdleSt;
      end
      // Terminal states, left only through reset
      default: stateD = stateQ;
    endcase
  end

  always_ff @(posedge clk_i) begin : stateReg
    if (reset_i) begin
      stateQ     <= lcCtrlPkg::ResetSt;
      transOk_o  <= 1'b0;
      transErr_o <= 1'b0;
    end else begin
      stateQ     <= stateD;
      transOk_o  <= transOkD;
      transErr_o <= transErrD;
    end
  end

  // Capture the target with the accepted request
  always_ff @(posedge clk_i) begin : targetReg
    if (stateQ == lcCtrlPkg::IdleSt && transReq_i) begin
      targetQ <= transTarget_i;
    end
  end

  assign fsmState_o = stateQ;

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // A request ends in OK or in error, never both
  okErrExclusiveA: assert property (@(posedge clk_i) disable iff (reset_i)
    !(transOk_o && transErr_o));

  // Terminal states hold until reset
  terminalHoldA: assert property (@(posedge clk_i) disable iff (reset_i)
    (stateQ inside {lcCtrlPkg::PostTransSt, lcCtrlPkg::EscalateSt,
                    lcCtrlPkg::InvalidSt, lcCtrlPkg::ScrapSt})
    |=> (stateQ == $past(stateQ)));

endmodule

//--- hw/lcCtrl.sv
// Life cycle controller top level
// Decoder and FSM instances, registered decoded outputs
`timescale 1ns/1ps
`include "lcCtrl_params.svh"

module lcCtrl (
  input  logic                          clk_i,
  input  logic                          reset_i,
  // OTP life cycle vector
  input  logic                          lcStateValid_i,
  input  lcCtrlStatePkg::lcStateE       lcState_i,
  input  lcCtrlStatePkg::lcCntE         lcCnt_i,
  input  lcCtrlPkg::lcTxT               secretsValid_i,
  input  logic                          escalate_i,
  // Transition request
  input  logic                          transReq_i,
  input  lcCtrlStatePkg::lcStateE       transTarget_i,
  // Decoded vector, one cycle behind the decoder
  output lcCtrlStatePkg::extDecLcStateT decLcState_o,
  output lcCtrlStatePkg::decLcCntT      decLcCnt_o,
  output lcCtrlStatePkg::decLcIdStateE  decLcIdState_o,
  output logic [`LC_NUM_ERR-1:0]        stateErr_o,
  // FSM status and transition result
  output lcCtrlPkg::fsmStateE           fsmState_o,
  output logic                          transOk_o,
  output logic                          transErr_o
);

  lcDecIf decIf ();
  lcCtrlPkg::fsmStateE fsmState;

  lcCtrlStateDecode stateDecode_inst (
    .clk_i          (clk_i),
    .lcStateValid_i (lcStateValid_i),
    .lcState_i      (lcState_i),
    .lcCnt_i        (lcCnt_i),
    .secretsValid_i (secretsValid_i),
    .fsmState_i     (fsmState),
    .dec_o          (decIf.decoder)
  );

  lcCtrlFsm fsm_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .escalate_i    (escalate_i),
    .transReq_i    (transReq_i),
    .transTarget_i (transTarget_i),
    .dec_i         (decIf.fsm),
    .fsmState_o    (fsmState),
    .transOk_o     (transOk_o),
    .transErr_o    (transErr_o)
  );

  assign fsmState_o = fsmState;

  // Output registers, reset to the ResetSt decode
  always_ff @(posedge clk_i) begin : outReg
    if (reset_i) begin
      decLcState_o   <= lcCtrlStatePkg::extDecLcStateT'(
                          {`LC_DEC_NUM_REP{lcCtrlStatePkg::DecLcStInvalid}});
      decLcCnt_o     <= {`LC_CNT_WIDTH{1'b1}};
      decLcIdState_o <= lcCtrlStatePkg::DecLcIdInvalid;
      stateErr_o     <= '0;
    end else begin
      decLcState_o   <= decIf.decState;
      decLcCnt_o     <= decIf.decCnt;
      decLcIdState_o <= decIf.decIdState;
      stateErr_o     <= decIf.stateErr;
    end
  end

endmodule

//--- testbench/lcCtrlTb.sv
// Life cycle controller testbench
// Clock and reset, stimulus, reference decode and FSM model,
// per-cycle compare process, compare tasks and watchdog
`timescale 1ns/1ps
`include "lcCtrl_params.svh"

module lcCtrlTb;

  localparam int ClkHalf = 4;
  localparam int NumTrans = 40;
  // Sweep, error cases, random trials and terminal tests, with margin
  localparam int WatchdogCycles = 100 + 20 * NumTrans + 20 * 6 + 80;

  // Expected registered decode
  typedef struct packed {
    lcCtrlStatePkg::extDecLcStateT st;
    lcCtrlStatePkg::decLcCntT      cnt;
    lcCtrlStatePkg::decLcIdStateE  id;
    logic [`LC_NUM_ERR-1:0]        err;
  } decVecT;

  logic                          clk;
  logic                          reset;
  logic                          lcStateValid;
  lcCtrlStatePkg::lcStateE       lcState;
  lcCtrlStatePkg::lcCntE         lcCnt;
  lcCtrlPkg::lcTxT               secretsValid;
  logic                          escalate;
  logic                          transReq;
  lcCtrlStatePkg::lcStateE       transTarget;
  lcCtrlStatePkg::extDecLcStateT decLcState;
  lcCtrlStatePkg::decLcCntT      decLcCnt;
  lcCtrlStatePkg::decLcIdStateE  decLcIdState;
  logic [`LC_NUM_ERR-1:0]        stateErr;
  lcCtrlPkg::fsmStateE           fsmState;
  logic                          transOk;
  logic                          transErr;

  logic [31:0] rngState = 32'h0a92_00e5;
  int          errCount = 0;

  lcCtrl lcCtrl_inst (
    .clk_i          (clk),
    .reset_i        (reset),
    .lcStateValid_i (lcStateValid),
    .lcState_i      (lcState),
    .lcCnt_i        (lcCnt),
    .secretsValid_i (secretsValid),
    .escalate_i     (escalate),
    .transReq_i     (transReq),
    .transTarget_i  (transTarget),
    .decLcState_o   (decLcState),
    .decLcCnt_o     (decLcCnt),
    .decLcIdState_o (decLcIdState),
    .stateErr_o     (stateErr),
    .fsmState_o     (fsmState),
    .transOk_o      (transOk),
    .transErr_o     (transErr)
  );

  initial begin : clockGen
    clk = 1'b0;
    forever #ClkHalf clk = ~clk;
  end

  //////////////////////////////
  // Helpers and reference
  //////////////////////////////

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // Declaration order of the enums is the rank order
  function automatic lcCtrlStatePkg::lcStateE stateAt(int rank);
    lcCtrlStatePkg::lcStateE e;
    e = e.first();
    repeat (rank) e = e.next();
    return e;
  endfunction

  function automatic lcCtrlStatePkg::lcCntE cntAt(int idx);
    lcCtrlStatePkg::lcCntE e;
    e = e.first();
    repeat (idx) e = e.next();
    return e;
  endfunction

  // -1 for a code outside the table
  function automatic int stateRank(lcCtrlStatePkg::lcStateE s);
    for (int i = 0; i < 21; i++) begin
      if (stateAt(i) == s) return i;
    end
    return -1;
  endfunction

  function automatic int cntRank(lcCtrlStatePkg::lcCntE c);
    for (int i = 0; i <= `LC_MAX_CNT; i++) begin
      if (cntAt(i) == c) return i;
    end
    return -1;
  endfunction

  function automatic decVecT refDecode(logic valid, lcCtrlStatePkg::lcStateE st,
                                       lcCtrlStatePkg::lcCntE cnt, lcCtrlPkg::lcTxT sec,
                                       lcCtrlPkg::fsmStateE fsm);
    decVecT d;
    lcCtrlStatePkg::decLcStateE stDec;
    int r;
    int c;
    stDec = lcCtrlStatePkg::DecLcStInvalid;
    d.cnt = 5'h1f;
    d.id  = lcCtrlStatePkg::DecLcIdInvalid;
    d.err = '0;
    r = stateRank(st);
    c = cntRank(cnt);
    case (fsm)
      lcCtrlPkg::ResetSt: begin
      end
      lcCtrlPkg::EscalateSt:  stDec = lcCtrlStatePkg::DecLcStEscalate;
      lcCtrlPkg::PostTransSt: stDec = lcCtrlStatePkg::DecLcStPostTrans;
      lcCtrlPkg::InvalidSt:   stDec = lcCtrlStatePkg::DecLcStInvalid;
      lcCtrlPkg::ScrapSt:     stDec = lcCtrlStatePkg::DecLcStScrap;
      default: begin
        d.err[lcCtrlPkg::ErrValid] = !valid;
        if (r < 0) d.err[lcCtrlPkg::ErrState] = 1'b1;
        else stDec = lcCtrlStatePkg::decLcStateE'(r);
        if (c < 0) d.err[lcCtrlPkg::ErrCnt] = 1'b1;
        else d.cnt = lcCtrlStatePkg::decLcCntT'(c);
        if (sec == lcCtrlPkg::On) d.id = lcCtrlStatePkg::DecLcIdPersonalized;
        else if (sec == lcCtrlPkg::Off) d.id = lcCtrlStatePkg::DecLcIdBlank;
        else d.err[lcCtrlPkg::ErrSecrets] = 1'b1;
        // Zero count only allowed in Raw
        d.err[lcCtrlPkg::ErrZeroCnt]   = (r != 0) && (c == 0);
        d.err[lcCtrlPkg::ErrPersoTest] = (sec == lcCtrlPkg::On) &&
                                         (r < stateRank(lcCtrlStatePkg::LcStDev));
      end
    endcase
    d.st = lcCtrlStatePkg::extDecLcStateT'({`LC_DEC_NUM_REP{stDec}});
    return d;
  endfunction

  // Forward moves only, with counter room left
  function automatic logic refTransLegal(lcCtrlStatePkg::lcStateE target,
                                         lcCtrlStatePkg::decLcStateE cur,
                                         lcCtrlStatePkg::decLcCntT cnt);
    return (stateRank(target) > int'(cur)) && (int'(cnt) < `LC_MAX_CNT);
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic failRun(string why);
    errCount++;
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic checkDecState(lcCtrlStatePkg::extDecLcStateT got,
                               lcCtrlStatePkg::extDecLcStateT exp);
    if (got !== exp || got != {`LC_DEC_NUM_REP{got[0]}})
      failRun($sformatf("CHECK FAILED t=%0t decLcState_o got=%h exp=%h", $time, got, exp));
  endtask

  task automatic checkCnt(lcCtrlStatePkg::decLcCntT got, lcCtrlStatePkg::decLcCntT exp);
    if (got !== exp)
      failRun($sformatf("CHECK FAILED t=%0t decLcCnt_o got=%0d exp=%0d", $time, got, exp));
  endtask

  task automatic checkId(lcCtrlStatePkg::decLcIdStateE got,
                         lcCtrlStatePkg::decLcIdStateE exp);
    if (got !== exp)
      failRun($sformatf("CHECK FAILED t=%0t decLcIdState_o got=%0d exp=%0d",
                        $time, got, exp));
  endtask

  task automatic checkErr(logic [`LC_NUM_ERR-1:0] got, logic [`LC_NUM_ERR-1:0] exp);
    if (got !== exp)
      failRun($sformatf("CHECK FAILED t=%0t stateErr_o got=%b exp=%b", $time, got, exp));
  endtask

  task automatic checkFsm(lcCtrlPkg::fsmStateE got, lcCtrlPkg::fsmStateE exp);
    if (got !== exp)
      failRun($sformatf("CHECK FAILED t=%0t fsmState_o got=%s exp=%s",
                        $time, got.name(), exp.name()));
  endtask

  task automatic checkStrobe(string name, logic got, logic exp);
    if (got !== exp)
      failRun($sformatf("CHECK FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp));
  endtask

  //////////////////////////////
  // Reference model and compare
  //////////////////////////////

  // Outputs are checked at the falling edge, then the model steps
  initial begin : compareProc
    decVecT                  d;
    decVecT                  expDec;
    lcCtrlPkg::fsmStateE     modelState;
    lcCtrlStatePkg::lcStateE modelTarget;
    logic                    expOk;
    logic                    expErr;
    logic                    legal;
    modelState  = lcCtrlPkg::ResetSt;
    modelTarget = lcCtrlStatePkg::LcStRaw;
    expDec      = refDecode(1'b1, lcCtrlStatePkg::LcStRaw, lcCtrlStatePkg::LcCnt0,
                            lcCtrlPkg::Off, lcCtrlPkg::ResetSt);
    expOk       = 1'b0;
    expErr      = 1'b0;
    @(posedge clk);
    forever begin
      @(negedge clk);
      checkDecState(decLcState, expDec.st);
      checkCnt(decLcCnt, expDec.cnt);
      checkId(decLcIdState, expDec.id);
      checkErr(stateErr, expDec.err);
      checkFsm(fsmState, modelState);
      checkStrobe("transOk_o", transOk, expOk);
      checkStrobe("transErr_o", transErr, expErr);
      expOk  = 1'b0;
      expErr = 1'b0;
      if (reset) begin
        modelState = lcCtrlPkg::ResetSt;
        expDec     = refDecode(1'b1, lcState, lcCnt, secretsValid, lcCtrlPkg::ResetSt);
      end else begin
        d      = refDecode(lcStateValid, lcState, lcCnt, secretsValid, modelState);
        expDec = d;
        case (modelState)
          lcCtrlPkg::ResetSt: modelState = lcCtrlPkg::IdleSt;
          lcCtrlPkg::IdleSt: begin
            if (escalate) modelState = lcCtrlPkg::EscalateSt;
            else if (|d.err) modelState = lcCtrlPkg::InvalidSt;
            else if (d.st[0] == lcCtrlStatePkg::DecLcStScrap) modelState = lcCtrlPkg::ScrapSt;
            else if (transReq) begin
              modelTarget = transTarget;
              modelState  = lcCtrlPkg::TransCheckSt;
            end
          end
          lcCtrlPkg::TransCheckSt: begin
            legal      = refTransLegal(modelTarget, d.st[0], d.cnt);
            expOk      = legal;
            expErr     = !legal;
            modelState = legal ? lcCtrlPkg::PostTransSt : lcCtrlPkg::IdleSt;
          end
          // Terminal states hold
          default: begin
          end
        endcase
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic driveVector(lcCtrlStatePkg::lcStateE st, lcCtrlStatePkg::lcCntE cnt,
                             lcCtrlPkg::lcTxT sec);
    lcStateValid <= 1'b1;
    lcState      <= st;
    lcCnt        <= cnt;
    secretsValid <= sec;
  endtask

  // Three reset cycles, returns with the FSM in IdleSt
  task automatic resetDut(lcCtrlStatePkg::lcStateE st, lcCtrlStatePkg::lcCntE cnt,
                          lcCtrlPkg::lcTxT sec);
    @(posedge clk);
    reset    <= 1'b1;
    escalate <= 1'b0;
    transReq <= 1'b0;
    driveVector(st, cnt, sec);
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic waitForState(lcCtrlPkg::fsmStateE st, int maxCycles);
    int n;
    n = 0;
    @(negedge clk);
    while (fsmState != st) begin
      if (n >= maxCycles)
        failRun($sformatf("Timeout while waiting for FSM state %s", st.name()));
      @(negedge clk);
      n++;
    end
  endtask

  // Counted from the edge after the request edge
  task automatic waitForResult(output logic ok);
    int n;
    @(negedge clk);
    n = 1;
    while (!(transOk || transErr)) begin
      if (n >= 8) failRun("No transition result arrived before the timeout");
      @(negedge clk);
      n++;
    end
    if (n != 2)
      failRun($sformatf("Transition result came %0d cycles late", n - 2));
    ok = transOk;
  endtask

  task automatic injectError(int errIdx);
    resetDut(lcCtrlStatePkg::LcStDev, lcCtrlStatePkg::LcCnt5, lcCtrlPkg::Off);
    @(posedge clk);
    case (errIdx)
      0: lcStateValid <= 1'b0;
      1: lcState      <= lcCtrlStatePkg::lcStateE'(32'hdead_beef);
      2: lcCnt        <= lcCtrlStatePkg::lcCntE'(16'hbeef);
      3: secretsValid <= lcCtrlPkg::lcTxT'(4'b0110);
      4: lcCnt        <= lcCtrlStatePkg::LcCnt0;
      default: begin
        lcState      <= lcCtrlStatePkg::LcStTestLocked3;
        secretsValid <= lcCtrlPkg::On;
      end
    endcase
    @(posedge clk);
    @(negedge clk);
    if (!stateErr[errIdx])
      failRun($sformatf("Error flag %0d was not raised by its error source", errIdx));
    waitForState(lcCtrlPkg::InvalidSt, 4);
    repeat (2) @(negedge clk);
  endtask

  task automatic runTransTrial();
    int                      rank;
    int                      cntIdx;
    lcCtrlPkg::lcTxT         sec;
    logic                    ok;
    // Scrap excluded as current state, it leaves IdleSt by itself
    rank   = int'(nextRand() % 20);
    cntIdx = (rank == 0) ? int'(nextRand() % 25) : 1 + int'(nextRand() % 24);
    sec    = (rank >= 16 && (nextRand() & 1)) ? lcCtrlPkg::On : lcCtrlPkg::Off;
    resetDut(stateAt(rank), cntAt(cntIdx), sec);
    transReq    <= 1'b1;
    transTarget <= stateAt(int'(nextRand() % 21));
    @(posedge clk);
    transReq <= 1'b0;
    waitForResult(ok);
    if (ok) waitForState(lcCtrlPkg::PostTransSt, 3);
  endtask

  initial begin : stimulus
    reset        <= 1'b1;
    lcStateValid <= 1'b1;
    lcState      <= lcCtrlStatePkg::LcStRaw;
    lcCnt        <= lcCtrlStatePkg::LcCnt0;
    secretsValid <= lcCtrlPkg::Off;
    escalate     <= 1'b0;
    transReq     <= 1'b0;
    transTarget  <= lcCtrlStatePkg::LcStRaw;
    resetDut(lcCtrlStatePkg::LcStRaw, lcCtrlStatePkg::LcCnt0, lcCtrlPkg::Off);

    // Every state but Scrap, then a count sweep in Dev
    for (int r = 0; r < 20; r++) begin
      driveVector(stateAt(r), cntAt(r == 0 ? 0 : 1 + r % 24),
                  r >= 16 ? lcCtrlPkg::On : lcCtrlPkg::Off);
      @(posedge clk);
    end
    for (int c = 1; c <= `LC_MAX_CNT; c++) begin
      driveVector(lcCtrlStatePkg::LcStDev, cntAt(c), lcCtrlPkg::On);
      @(posedge clk);
    end
    @(negedge clk);
    checkFsm(fsmState, lcCtrlPkg::IdleSt);

    for (int e = 0; e < `LC_NUM_ERR; e++) injectError(e);
    for (int t = 0; t < NumTrans; t++) runTransTrial();

    // Escalation, late request is ignored
    resetDut(lcCtrlStatePkg::LcStProd, lcCtrlStatePkg::LcCnt7, lcCtrlPkg::On);
    escalate <= 1'b1;
    @(posedge clk);
    escalate    <= 1'b0;
    transReq    <= 1'b1;
    transTarget <= lcCtrlStatePkg::LcStRma;
    @(posedge clk);
    transReq <= 1'b0;
    waitForState(lcCtrlPkg::EscalateSt, 4);
    repeat (6) @(posedge clk);

    // OTP Scrap, escalation no longer matters
    resetDut(lcCtrlStatePkg::LcStScrap, lcCtrlStatePkg::LcCnt10, lcCtrlPkg::On);
    waitForState(lcCtrlPkg::ScrapSt, 4);
    @(posedge clk);
    escalate <= 1'b1;
    repeat (6) @(posedge clk);
    escalate <= 1'b0;

    resetDut(lcCtrlStatePkg::LcStRaw, lcCtrlStatePkg::LcCnt0, lcCtrlPkg::Off);
    @(negedge clk);
    if (errCount == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      failRun("Run ended with failed checks");
    end
  end

  // Hang guard
  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk);
    failRun("Watchdog expired before the test sequence finished");
  end

endmodule

//--- verilog.f
+incdir+hw
hw/lcCtrlStatePkg.sv
hw/lcCtrlPkg.sv
hw/lcDecIf.sv
hw/lcCtrlStateDecode.sv
hw/lcCtrlFsm.sv
hw/lcCtrl.sv
testbench/lcCtrlTb.sv

//--- run_sim.sh
#!/bin/sh
# Build the life cycle controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module lcCtrlTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VlcCtrlTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
fi

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
